//--- filelist.f
common/axil_hub_pkg.sv
mem_target/mem_target.sv
rtl/ctrl_reg_target.sv
rtl/target_select.sv
rtl/axil_target_hub.sv
tests/axil_target_hub_sva.sv
tests/axil_target_hub_tb.sv

//--- tests/axil_target_hub_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axil_target_hub_tb;

	import axil_hub_pkg::*;

	localparam int clk_period = 40;
	localparam int reset_cycles = 10;
	localparam int wait_limit = 30;	// Handshake cycles, on top of the row's hold
	localparam int row_bound = 60;

	typedef enum logic [1:0] {
		op_write = 2'd0,
		op_read = 2'd1,
		op_idle = 2'd2	// Read that must go unanswered
	} op_e;

	typedef struct packed {
		op_e op;
		target_e tgt;
		addr_t addr;
		data_t wdata;
		strb_t strb;
		logic [7:0] hold;	// rready low cycles, data lag on writes
		data_t exp_val;	// rdata, or io_ctrl after a write
	} row_t;

	logic axi_clk;
	logic axi_reset_n;
	axil_req_t req;
	target_e target_sel;
	axil_rsp_t rsp;
	io_ctrl_t io_ctrl;

	row_t stim_q[$];
	data_t mem_model [0:mem_depth-1];
	logic [1:0] ctrl_bits;	// Bit 0 rxen, bit 1 txen
	logic [31:0] lfsr_state;
	int errors;
	int checks;

	axil_target_hub axil_target_hub_i (
		.axi_clk(axi_clk),
		.axi_reset_n(axi_reset_n),
		.req(req),
		.target_sel(target_sel),
		.rsp(rsp),
		.io_ctrl(io_ctrl)
	);

	initial begin
		axi_clk = 1'b0;
		forever #(clk_period / 2) axi_clk = ~axi_clk;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %0t %s: got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	function automatic data_t next_random_word();
		data_t word;
		word = '0;
		for (int i = 0; i < data_w; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			word = {word[data_w-2:0], lfsr_state[0]};
		end
		return word;
	endfunction

	//////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////
	function automatic void add_row(input op_e op, input target_e tgt, input addr_t addr,
		input data_t wdata, input strb_t strb, input int hold, input data_t exp_val);
		row_t row;
		row.op = op;
		row.tgt = tgt;
		row.addr = addr;
		row.wdata = wdata;
		row.strb = strb;
		row.hold = hold[7:0];
		row.exp_val = exp_val;
		stim_q.push_back(row);
	endfunction

	// Whole word lands whatever the strobes
	function automatic void add_mem_write(input addr_t addr, input strb_t strb, input int lag);
		data_t word;
		word = next_random_word();
		mem_model[addr[7:0]] = word;
		add_row(op_write, tgt_mem, addr, word, strb, lag, {30'b0, ctrl_bits});
	endfunction

	function automatic void add_mem_read(input addr_t addr, input int hold);
		add_row(op_read, tgt_mem, addr, '0, '0, hold, mem_model[addr[7:0]]);
	endfunction

	function automatic void add_ctrl_write(input addr_t addr, input data_t wdata,
		input strb_t strb);
		if (addr[11:0] == 12'h000 && strb[0]) begin
			ctrl_bits = wdata[1:0];
		end
		add_row(op_write, tgt_ctrl, addr, wdata, strb, 0, {30'b0, ctrl_bits});
	endfunction

	function automatic void add_ctrl_read(input int hold);
		add_row(op_read, tgt_ctrl, '0, '0, '0, hold, {30'b0, ctrl_bits});
	endfunction

	function automatic void build_table();
		add_mem_write(15'h0000, 4'hf, 0);
		add_mem_write(15'h0005, 4'h1, 0);	// Partial strobes
		add_mem_write(15'h207f, 4'h8, 0);
		add_mem_write(15'h00ff, 4'hf, 0);
		add_mem_read(15'h0000, 0);
		add_mem_read(15'h0005, 0);
		add_mem_read(15'h007f, 0);
		add_mem_read(15'h10ff, 0);
		add_mem_write(15'h0040, 4'hf, 3);	// Data three cycles after address
		add_mem_read(15'h0040, 0);
		add_mem_read(15'h0005, 6);
		add_ctrl_write(15'h0000, 32'h0000_0003, 4'h1);
		add_ctrl_read(0);
		add_ctrl_write(15'h0000, 32'hffff_fffe, 4'hf);
		add_ctrl_read(0);
		add_ctrl_write(15'h0004, 32'h0000_0001, 4'hf);	// Wrong offset
		add_ctrl_write(15'h0000, 32'h0000_0001, 4'he);	// Strobe bit 0 clear
		add_ctrl_read(3);
		add_ctrl_write(15'h1000, 32'h0000_0001, 4'h1);
		add_ctrl_read(0);
		add_row(op_idle, tgt_none, 15'h0000, '0, '0, 8, '0);
		add_mem_read(15'h0000, 0);
		add_mem_read(15'h00ff, 2);
		add_mem_read(15'h0040, 0);
	endfunction

	//////////////////////////////////////////////////
	// Transactions
	//////////////////////////////////////////////////
	task automatic run_row(input row_t row);
		int cycles;
		int held;
		logic aw_done;
		logic w_done;
		logic r_done;
		logic seen_rvalid;
		cycles = 0;
		held = 0;
		aw_done = 1'b0;
		w_done = 1'b0;
		r_done = 1'b0;
		seen_rvalid = 1'b0;
		@(posedge axi_clk);
		target_sel <= row.tgt;
		case (row.op)
			op_write: begin
				req.awvalid <= 1'b1;
				req.awaddr <= row.addr;
				req.wdata <= row.wdata;
				req.wstrb <= row.strb;
				req.wvalid <= (row.hold == 0);
				while (!(aw_done && w_done) && cycles < wait_limit + int'(row.hold)) begin
					@(posedge axi_clk);
					cycles++;
					if (rsp.awready && req.awvalid) begin
						req.awvalid <= 1'b0;
						aw_done = 1'b1;
					end
					if (rsp.wready && req.wvalid) begin
						req.wvalid <= 1'b0;
						w_done = 1'b1;
					end else if (!w_done && cycles == int'(row.hold)) begin
						req.wvalid <= 1'b1;
					end
				end
				if (!(aw_done && w_done)) begin
					errors++;
					$display("Write to address %h on %s was not accepted in time",
						row.addr, row.tgt.name());
				end
				req.awvalid <= 1'b0;
				req.wvalid <= 1'b0;
				@(posedge axi_clk);
				check_value("io_ctrl", {30'b0, io_ctrl.txen, io_ctrl.rxen}, row.exp_val);
			end
			op_read: begin
				req.arvalid <= 1'b1;
				req.araddr <= row.addr;
				req.rready <= (row.hold == 0);
				while (!r_done && cycles < wait_limit + int'(row.hold)) begin
					@(posedge axi_clk);
					cycles++;
					if (rsp.arready && req.arvalid) begin
						req.arvalid <= 1'b0;
					end
					if (seen_rvalid) begin
						check_value("rvalid", rsp.rvalid, 1'b1);
						check_value("rdata", rsp.rdata, row.exp_val);	// Held data
					end else if (rsp.rvalid) begin
						seen_rvalid = 1'b1;
					end
					if (rsp.rvalid && req.rready) begin
						r_done = 1'b1;
						req.rready <= 1'b0;
						check_value("rdata", rsp.rdata, row.exp_val);
					end else if (rsp.rvalid) begin
						held++;
						if (held >= int'(row.hold)) begin
							req.rready <= 1'b1;
						end
					end
				end
				if (!r_done) begin
					errors++;
					$display("Read at address %h on %s returned no data in time",
						row.addr, row.tgt.name());
				end
				req.arvalid <= 1'b0;
				req.rready <= 1'b0;
			end
			default: begin
				req.arvalid <= 1'b1;
				req.araddr <= row.addr;
				req.rready <= 1'b1;
				repeat (row.hold) begin
					@(posedge axi_clk);
					check_value("arready", rsp.arready, 1'b0);
					check_value("rvalid", rsp.rvalid, 1'b0);
				end
				req.arvalid <= 1'b0;
				req.rready <= 1'b0;
			end
		endcase
	endtask

	initial begin
		errors = 0;
		checks = 0;
		lfsr_state = 32'd10;
		ctrl_bits = 2'b00;
		axi_reset_n = 1'b0;
		req = '0;
		target_sel = tgt_none;
		build_table();
		repeat (reset_cycles) @(posedge axi_clk);
		axi_reset_n <= 1'b1;
		@(posedge axi_clk);
		check_value("ready and valid", {rsp.awready, rsp.wready, rsp.arready, rsp.rvalid}, 0);
		check_value("io_ctrl", {30'b0, io_ctrl.txen, io_ctrl.rxen}, 0);
		foreach (stim_q[i]) begin
			run_row(stim_q[i]);
		end
		repeat (2) @(posedge axi_clk);
		errors += axil_target_hub_i.protocol_sva_i.fail_count;
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		@(posedge axi_reset_n);
		repeat (stim_q.size() * row_bound) @(posedge axi_clk);
		$display("Watchdog expired, the run did not finish in %0d cycles",
			stim_q.size() * row_bound);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/axil_target_hub_sva.sv
`timescale 1ns/1ps
`default_nettype none

module axil_target_hub_sva (
	input logic axi_clk,
	input logic axi_reset_n,
	input axil_hub_pkg::axil_req_t req,
	input axil_hub_pkg::target_e target_sel,
	input axil_hub_pkg::axil_rsp_t mem_rsp
);

	import axil_hub_pkg::*;

	int fail_count = 0;	// Failed assertions so far

	// Memory read data held under back-pressure
	rdata_stable: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		(target_sel == tgt_mem && mem_rsp.rvalid && !req.rready) |=>
		(target_sel != tgt_mem) || (mem_rsp.rvalid && $stable(mem_rsp.rdata)))
	else begin
		fail_count++;
		$error("memory rvalid or rdata changed while rready was low");
	end

	// Memory bank cleared one cycle into a deselect
	none_quiet: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		(target_sel == tgt_none) |=> (target_sel != tgt_none) ||
		!(mem_rsp.awready || mem_rsp.wready || mem_rsp.arready || mem_rsp.rvalid))
	else begin
		fail_count++;
		$error("memory bank ready or rvalid high with no target selected");
	end

	arready_pulse: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		mem_rsp.arready |=> !mem_rsp.arready)
	else begin
		fail_count++;
		$error("memory arready high for two cycles");
	end

endmodule

bind axil_target_hub axil_target_hub_sva protocol_sva_i (
	.axi_clk(axi_clk),
	.axi_reset_n(axi_reset_n),
	.req(req),
	.target_sel(target_sel),
	.mem_rsp(mem_rsp)
);

`default_nettype wire

//--- rtl/axil_target_hub.sv
`timescale 1ns/1ps
`default_nettype none

module axil_target_hub (
	input logic axi_clk,
	input logic axi_reset_n,
	input axil_hub_pkg::axil_req_t req,
	input axil_hub_pkg::target_e target_sel,
	output axil_hub_pkg::axil_rsp_t rsp,
	output axil_hub_pkg::io_ctrl_t io_ctrl
);

	import axil_hub_pkg::*;

	axil_req_t mem_req;
	axil_req_t ctrl_req;
	axil_rsp_t mem_rsp;
	axil_rsp_t ctrl_rsp;
	logic mem_enable;
	logic ctrl_enable;

	//////////////////////////////////////////////////
	// Routing
	//////////////////////////////////////////////////
	target_select target_select_i (
		.req(req),
		.target_sel(target_sel),
		.mem_rsp(mem_rsp),
		.ctrl_rsp(ctrl_rsp),
		.mem_req(mem_req),
		.ctrl_req(ctrl_req),
		.mem_enable(mem_enable),
		.ctrl_enable(ctrl_enable),
		.rsp(rsp)
	);

	//////////////////////////////////////////////////
	// Targets
	//////////////////////////////////////////////////

	// 256-word memory bank
	mem_target mem_target_i (
		.axi_clk(axi_clk),
		.axi_reset_n(axi_reset_n),
		.enable(mem_enable),
		.req(mem_req),
		.rsp(mem_rsp)
	);

	// Receive and transmit enables
	ctrl_reg_target ctrl_reg_target_i (
		.axi_clk(axi_clk),
		.axi_reset_n(axi_reset_n),
		.enable(ctrl_enable),
		.req(ctrl_req),
		.rsp(ctrl_rsp),
		.io_ctrl(io_ctrl)
	);

endmodule

`default_nettype wire

//--- rtl/target_select.sv
`timescale 1ns/1ps
`default_nettype none

module target_select (
	input axil_hub_pkg::axil_req_t req,
	input axil_hub_pkg::target_e target_sel,
	input axil_hub_pkg::axil_rsp_t mem_rsp,
	input axil_hub_pkg::axil_rsp_t ctrl_rsp,
	output axil_hub_pkg::axil_req_t mem_req,
	output axil_hub_pkg::axil_req_t ctrl_req,
	output logic mem_enable,
	output logic ctrl_enable,
	output axil_hub_pkg::axil_rsp_t rsp
);

	import axil_hub_pkg::*;

	logic mem_sel;
	logic ctrl_sel;

	// Valids dropped for a target that is not selected
	function automatic axil_req_t gate_req(input axil_req_t in_req, input logic sel);
		axil_req_t out_req;
		out_req = in_req;
		out_req.awvalid = in_req.awvalid && sel;
		out_req.wvalid = in_req.wvalid && sel;
		out_req.arvalid = in_req.arvalid && sel;
		return out_req;
	endfunction

	//////////////////////////////////////////////////
	// Target decode
	//////////////////////////////////////////////////
	always_comb begin
		mem_sel = 1'b0;
		ctrl_sel = 1'b0;
		case (target_sel)
			tgt_mem: mem_sel = 1'b1;
			tgt_ctrl: ctrl_sel = 1'b1;
			default: begin
				mem_sel = 1'b0;	// tgt_none
				ctrl_sel = 1'b0;
			end
		endcase
	end

	assign mem_enable = mem_sel;
	assign ctrl_enable = ctrl_sel;

	// Request fan-out
	always_comb begin
		mem_req = gate_req(req, mem_sel);
		ctrl_req = gate_req(req, ctrl_sel);
	end

	//////////////////////////////////////////////////
	// Response mux
	//////////////////////////////////////////////////
	always_comb begin
		if (mem_sel) begin
			rsp = mem_rsp;
		end else if (ctrl_sel) begin
			rsp = ctrl_rsp;
		end else begin
			rsp = '0;	// Nothing selected
		end
	end

endmodule

`default_nettype wire

//--- rtl/ctrl_reg_target.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_reg_target (
	input logic axi_clk,
	input logic axi_reset_n,
	input logic enable,
	input axil_hub_pkg::axil_req_t req,
	output axil_hub_pkg::axil_rsp_t rsp,
	output axil_hub_pkg::io_ctrl_t io_ctrl
);

	import axil_hub_pkg::*;

	logic wr_fire;
	logic wr_hit;
	reg_offset_t wr_offset;

	// Address and data must arrive together
	assign wr_fire = enable && req.awvalid && req.wvalid;
	assign wr_offset = req.awaddr[reg_offset_w-1:0];
	assign wr_hit = wr_fire && (wr_offset == ctrl_offset) && req.wstrb[0];

	//////////////////////////////////////////////////
	// Response without latency
	//////////////////////////////////////////////////
	always_comb begin
		rsp = '0;
		rsp.awready = wr_fire;
		rsp.wready = wr_fire;
		if (enable) begin
			rsp.arready = 1'b1;
			rsp.rvalid = 1'b1;
			rsp.rdata = {{(data_w-2){1'b0}}, io_ctrl.txen, io_ctrl.rxen};
		end
	end

	//////////////////////////////////////////////////
	// IO control bits
	//////////////////////////////////////////////////
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			io_ctrl <= '0;
		end else if (wr_hit) begin
			io_ctrl.rxen <= req.wdata[0];
			io_ctrl.txen <= req.wdata[1];
		end
	end

endmodule

`default_nettype wire

//--- mem_target/mem_target.sv
`timescale 1ns/1ps
`default_nettype none

module mem_target (
	input logic axi_clk,
	input logic axi_reset_n,
	input logic enable,
	input axil_hub_pkg::axil_req_t req,
	output axil_hub_pkg::axil_rsp_t rsp
);

	import axil_hub_pkg::*;

	target_state_e state;

	mem_index_t idx_q;	// Word index of the pending access
	data_t wdata_q;
	data_t mem [0:mem_depth-1];

	logic rd_start;
	logic wr_start;
	logic wr_data_take;

	//////////////////////////////////////////////////
	// Request decode
	//////////////////////////////////////////////////

	// Read wins over write in the same cycle
	assign rd_start = enable && (state == st_idle) && req.arvalid;
	assign wr_start = enable && (state == st_idle) && !req.arvalid && req.awvalid;

	// Data taken with the address, or later in st_write_data
	always_comb begin
		wr_data_take = 1'b0;
		if (wr_start && req.wvalid) begin
			wr_data_take = 1'b1;
		end else if (enable && (state == st_write_data) && req.wvalid) begin
			wr_data_take = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Handshake machine
	//////////////////////////////////////////////////
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state <= st_idle;
			rsp <= '0;
		end else if (!enable) begin
			// Back to idle when deselected
			state <= st_idle;
			rsp <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (rd_start) begin
						rsp.arready <= 1'b1;
						state <= st_read_data;
					end else if (wr_start && req.wvalid) begin
						rsp.awready <= 1'b1;
						rsp.wready <= 1'b1;
						state <= st_write_complete;
					end else if (wr_start) begin
						rsp.awready <= 1'b1;
						state <= st_write_data;
					end
				end

				st_read_data: begin
					rsp.arready <= 1'b0;
					rsp.rdata <= mem[idx_q];
					rsp.rvalid <= 1'b1;
					state <= st_read_complete;
				end

				st_read_complete: begin
					// Held here under back-pressure
					if (req.rready) begin
						rsp.rdata <= '0;
						rsp.rvalid <= 1'b0;
						state <= st_idle;
					end
				end

				st_write_data: begin
					rsp.awready <= 1'b0;
					if (wr_data_take) begin
						rsp.wready <= 1'b1;
						state <= st_write_complete;
					end
				end

				st_write_complete: begin
					rsp.awready <= 1'b0;
					rsp.wready <= 1'b0;
					state <= st_idle;
				end

				default: begin
					rsp <= '0;
					state <= st_idle;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Address and data capture
	//////////////////////////////////////////////////
	always_ff @(posedge axi_clk) begin
		if (rd_start) begin
			idx_q <= req.araddr[mem_index_w-1:0];
		end else if (wr_start) begin
			idx_q <= req.awaddr[mem_index_w-1:0];
		end
	end

	always_ff @(posedge axi_clk) begin
		if (wr_data_take) begin
			wdata_q <= req.wdata;	// Whole word, strobes ignored
		end
	end

	// Storage kept across deselect
	always_ff @(posedge axi_clk) begin
		if (enable && (state == st_write_complete)) begin
			mem[idx_q] <= wdata_q;
		end
	end

endmodule

`default_nettype wire

//--- common/axil_hub_pkg.sv
`default_nettype none

package axil_hub_pkg;

	//////////////////////////////////////////////////
	// Widths and sizes
	//////////////////////////////////////////////////
	localparam int addr_w = 15;
	localparam int data_w = 32;
	localparam int strb_w = data_w / 8;
	localparam int mem_depth = 256;
	localparam int mem_index_w = $clog2(mem_depth);
	localparam int reg_offset_w = 12;

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [data_w-1:0] data_t;
	typedef logic [strb_w-1:0] strb_t;
	typedef logic [mem_index_w-1:0] mem_index_t;
	typedef logic [reg_offset_w-1:0] reg_offset_t;

	localparam reg_offset_t ctrl_offset = 12'h000;	// IO control register

	typedef enum logic [1:0] {
		tgt_none = 2'd0,
		tgt_mem = 2'd1,
		tgt_ctrl = 2'd2
	} target_e;

	// Target handshake machine
	typedef enum logic [2:0] {
		st_idle = 3'd0,
		st_read_data = 3'd1,
		st_read_complete = 3'd2,
		st_write_data = 3'd3,
		st_write_complete = 3'd4
	} target_state_e;

	//////////////////////////////////////////////////
	// AXI-Lite request and response
	//////////////////////////////////////////////////
	typedef struct packed {
		logic awvalid;
		addr_t awaddr;
		logic wvalid;
		data_t wdata;
		strb_t wstrb;
		logic arvalid;
		addr_t araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic arready;
		logic rvalid;
		data_t rdata;
	} axil_rsp_t;

	typedef struct packed {
		logic rxen;
		logic txen;
	} io_ctrl_t;

endpackage

`default_nettype wire
